//--- hw/sysctl_pkg.sv
// Shared CSR widths, bank numbers, register offsets and keys; import into any block on the CSR bus

package sysctl_pkg;

	// ------------------------------
	// Bus word types
	// ------------------------------
	typedef logic [31:0] wb_addr_t;
	typedef logic [31:0] csr_data_t;
	// Word address without the byte bits
	typedef logic [13:0] csr_addr_t;
	typedef logic [3:0]  csr_bank_t;
	typedef logic [9:0]  csr_reg_t;
	typedef logic [2:0]  irq_vec_t;

	// Interrupt vector bit positions
	localparam int IRQ_GPIO   = 0;
	localparam int IRQ_TIMER0 = 1;
	localparam int IRQ_TIMER1 = 2;

	// ------------------------------
	// CSR map
	// ------------------------------
	localparam csr_bank_t GPIO_BANK   = 4'd1;
	localparam csr_bank_t TIMER0_BANK = 4'd2;
	localparam csr_bank_t TIMER1_BANK = 4'd3;

	localparam csr_reg_t GPIO_IN      = 10'd0;
	localparam csr_reg_t GPIO_OUT     = 10'd1;
	localparam csr_reg_t GPIO_MASK    = 10'd2;
	localparam csr_reg_t GPIO_PENDING = 10'd3;
	localparam csr_reg_t GPIO_RESET   = 10'd4;

	localparam csr_reg_t TIMER_CTRL    = 10'd0;
	localparam csr_reg_t TIMER_COMPARE = 10'd1;
	localparam csr_reg_t TIMER_COUNTER = 10'd2;

	// Magic value that triggers a full system reset
	localparam csr_data_t HARD_RESET_KEY = 32'h0000_5A5A;

	// Upper address bits select the bank
	function automatic csr_bank_t csr_bank_of(input csr_addr_t a);
		return a[13:10];
	endfunction

	function automatic csr_reg_t csr_reg_of(input csr_addr_t a);
		return a[9:0];
	endfunction

endpackage

//--- hw/reset_sequencer.sv
// Debounced system reset with early flash reset release; drive from the external reset trigger
`timescale 1ns/1ps

module reset_sequencer #(
	parameter int DEBOUNCE_CYCLES  = 16,
	parameter int FLASH_RST_CYCLES = 8
) (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic hard_reset_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	// Flash must leave reset before the system does,
	// so FLASH_RST_CYCLES stays below DEBOUNCE_CYCLES
	localparam int DEB_W   = $clog2(DEBOUNCE_CYCLES + 1);
	localparam int FLASH_W = $clog2(FLASH_RST_CYCLES + 1);

	logic               trigger;
	logic [DEB_W-1:0]   debounce_cnt;
	logic [FLASH_W-1:0] flash_cnt;

	assign trigger = trigger_reset | hard_reset_i;

	// ------------------------------
	// Debounce counter
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (trigger) begin
			debounce_cnt <= DEB_W'(DEBOUNCE_CYCLES);
		end else if (debounce_cnt != '0) begin
			debounce_cnt <= debounce_cnt - 1'b1;
		end
	end

	// Held high while triggered, falls one cycle after the count expires
	always_ff @(posedge sys_clk) begin
		sys_rst_o <= trigger | (debounce_cnt != '0);
	end

	// ------------------------------
	// Flash release counter
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (trigger) begin
			flash_cnt <= FLASH_W'(FLASH_RST_CYCLES);
		end else if (flash_cnt != '0) begin
			flash_cnt <= flash_cnt - 1'b1;
		end
	end

	assign flash_rst_n_o = (flash_cnt == '0);

endmodule

//--- hw/wb_csr_bridge.sv
// Wishbone slave to CSR bus bridge; each access runs a fixed four-cycle sequence ending in ack
`timescale 1ns/1ps

module wb_csr_bridge (
	input  logic                  sys_clk,
	input  logic                  sys_rst_i,
	input  sysctl_pkg::wb_addr_t  wb_adr_i,
	input  sysctl_pkg::csr_data_t wb_dat_i,
	input  logic                  wb_we_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	output sysctl_pkg::csr_data_t wb_dat_o,
	output logic                  wb_ack_o,
	output sysctl_pkg::csr_addr_t csr_a_o,
	output logic                  csr_we_o,
	output sysctl_pkg::csr_data_t csr_dw_o,
	input  sysctl_pkg::csr_data_t csr_di_i
);
	import sysctl_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		READ,
		ACK
	} state_t;

	state_t state;
	logic   accept;

	assign accept = (state == IDLE) & wb_cyc_i & wb_stb_i;

	// ------------------------------
	// Access sequencer
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state    <= IDLE;
			csr_we_o <= 1'b0;
			wb_ack_o <= 1'b0;
		end else begin
			csr_we_o <= 1'b0;
			wb_ack_o <= 1'b0;
			case (state)
				IDLE: begin
					if (accept) begin
						state    <= ADDR;
						csr_we_o <= wb_we_i;
					end
				end
				// Banks see the address now and answer next cycle
				ADDR: state <= READ;
				READ: begin
					state    <= ACK;
					wb_ack_o <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Address and write data captured on acceptance
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			csr_a_o  <= wb_adr_i[15:2];
			csr_dw_o <= wb_dat_i;
		end
	end

	// OR-combined bank data is valid in READ
	always_ff @(posedge sys_clk) begin
		if (state == READ) begin
			wb_dat_o <= csr_di_i;
		end
	end

endmodule

//--- hw/gpio_ctl.sv
// GPIO CSR bank with change interrupts and hard reset request; instantiate once on the CSR bus
`timescale 1ns/1ps

module gpio_ctl #(
	parameter sysctl_pkg::csr_bank_t BANK = 4'd1,
	parameter int NINPUTS  = 7,
	parameter int NOUTPUTS = 2
) (
	input  logic                  sys_clk,
	input  logic                  sys_rst_i,
	input  sysctl_pkg::csr_addr_t csr_a_i,
	input  logic                  csr_we_i,
	input  sysctl_pkg::csr_data_t csr_di_i,
	output sysctl_pkg::csr_data_t csr_do_o,
	input  logic [NINPUTS-1:0]    gpio_in_i,
	output logic [NOUTPUTS-1:0]   gpio_out_o,
	output logic                  irq_o,
	output logic                  hard_reset_o
);
	import sysctl_pkg::*;

	logic [NINPUTS-1:0] in_meta;
	logic [NINPUTS-1:0] in_sync;
	logic [NINPUTS-1:0] in_prev;
	logic [NINPUTS-1:0] mask;
	logic [NINPUTS-1:0] pending;
	logic [NINPUTS-1:0] changed;
	logic               sel;
	logic               wr;
	csr_reg_t           reg_idx;

	assign sel     = (csr_bank_of(csr_a_i) == BANK);
	assign wr      = sel & csr_we_i;
	assign reg_idx = csr_reg_of(csr_a_i);

	// ------------------------------
	// Input synchronizer
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		in_meta <= gpio_in_i;
		in_sync <= in_meta;
		in_prev <= in_sync;
	end

	assign changed = in_sync ^ in_prev;

	// ------------------------------
	// Control registers
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out_o   <= '0;
			mask         <= '0;
			pending      <= '0;
			hard_reset_o <= 1'b0;
		end else begin
			hard_reset_o <= wr & (reg_idx == GPIO_RESET) & (csr_di_i == HARD_RESET_KEY);
			if (wr && reg_idx == GPIO_OUT) begin
				gpio_out_o <= csr_di_i[NOUTPUTS-1:0];
			end
			if (wr && reg_idx == GPIO_MASK) begin
				mask <= csr_di_i[NINPUTS-1:0];
			end
			// A new edge wins over a write-1 clear in the same cycle
			if (wr && reg_idx == GPIO_PENDING) begin
				pending <= (pending & ~csr_di_i[NINPUTS-1:0]) | (changed & mask);
			end else begin
				pending <= pending | (changed & mask);
			end
		end
	end

	assign irq_o = |pending;

	// Read port drives zero when another bank is addressed
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			csr_do_o <= '0;
		end else begin
			csr_do_o <= '0;
			if (sel) begin
				case (reg_idx)
					GPIO_IN:      csr_do_o <= csr_data_t'(in_sync);
					GPIO_OUT:     csr_do_o <= csr_data_t'(gpio_out_o);
					GPIO_MASK:    csr_do_o <= csr_data_t'(mask);
					GPIO_PENDING: csr_do_o <= csr_data_t'(pending);
					default:      csr_do_o <= '0;
				endcase
			end
		end
	end

endmodule

//--- hw/sys_timer.sv
// Interval timer CSR bank with match interrupt and autorestart; instantiate once per bank number
`timescale 1ns/1ps

module sys_timer #(
	parameter sysctl_pkg::csr_bank_t BANK = 4'd2
) (
	input  logic                  sys_clk,
	input  logic                  sys_rst_i,
	input  sysctl_pkg::csr_addr_t csr_a_i,
	input  logic                  csr_we_i,
	input  sysctl_pkg::csr_data_t csr_di_i,
	output sysctl_pkg::csr_data_t csr_do_o,
	output logic                  irq_o
);
	import sysctl_pkg::*;

	// CTRL bit positions
	localparam int CTRL_EN   = 0;
	localparam int CTRL_AUTO = 1;
	localparam int CTRL_DONE = 2;

	logic      enable;
	logic      autorestart;
	logic      done;
	csr_data_t compare;
	csr_data_t counter;
	logic      sel;
	logic      wr;
	csr_reg_t  reg_idx;

	assign sel     = (csr_bank_of(csr_a_i) == BANK);
	assign wr      = sel & csr_we_i;
	assign reg_idx = csr_reg_of(csr_a_i);

	// ------------------------------
	// Counter and match logic
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			enable      <= 1'b0;
			autorestart <= 1'b0;
			done        <= 1'b0;
			compare     <= '0;
			counter     <= '0;
			irq_o       <= 1'b0;
		end else begin
			irq_o <= 1'b0;
			if (enable) begin
				if (counter == compare) begin
					irq_o <= 1'b1;
					done  <= 1'b1;
					// One-shot mode stops and holds at the compare value
					if (autorestart) begin
						counter <= '0;
					end else begin
						enable <= 1'b0;
					end
				end else begin
					counter <= counter + 1'b1;
				end
			end
			// Bus writes take priority over the running count
			if (wr && reg_idx == TIMER_CTRL) begin
				enable      <= csr_di_i[CTRL_EN];
				autorestart <= csr_di_i[CTRL_AUTO];
				done        <= 1'b0;
			end
			if (wr && reg_idx == TIMER_COMPARE) begin
				compare <= csr_di_i;
			end
			if (wr && reg_idx == TIMER_COUNTER) begin
				counter <= csr_di_i;
			end
		end
	end

	// Read port
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			csr_do_o <= '0;
		end else begin
			csr_do_o <= '0;
			if (sel) begin
				case (reg_idx)
					TIMER_CTRL: begin
						csr_do_o[CTRL_EN]   <= enable;
						csr_do_o[CTRL_AUTO] <= autorestart;
						csr_do_o[CTRL_DONE] <= done;
					end
					TIMER_COMPARE: csr_do_o <= compare;
					TIMER_COUNTER: csr_do_o <= counter;
					default:       csr_do_o <= '0;
				endcase
			end
		end
	end

endmodule

//--- hw/sysctl_top.sv
// System controller top; connects reset sequencing, the Wishbone to CSR bridge and the CSR banks
`timescale 1ns/1ps

module sysctl_top #(
	parameter int NINPUTS          = 7,
	parameter int NOUTPUTS         = 2,
	parameter int DEBOUNCE_CYCLES  = 16,
	parameter int FLASH_RST_CYCLES = 8
) (
	input  logic                  sys_clk,
	input  logic                  trigger_reset,
	input  sysctl_pkg::wb_addr_t  wb_adr_i,
	input  sysctl_pkg::csr_data_t wb_dat_i,
	input  logic                  wb_we_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	output sysctl_pkg::csr_data_t wb_dat_o,
	output logic                  wb_ack_o,
	input  logic [NINPUTS-1:0]    gpio_in_i,
	output logic [NOUTPUTS-1:0]   gpio_out_o,
	output sysctl_pkg::irq_vec_t  irq_o,
	output logic                  flash_rst_n_o,
	output logic                  periph_rst_n_o
);
	import sysctl_pkg::*;

	logic      sys_rst;
	logic      hard_reset;
	csr_addr_t csr_a;
	logic      csr_we;
	csr_data_t csr_dw;
	csr_data_t csr_dr_gpio;
	csr_data_t csr_dr_timer0;
	csr_data_t csr_dr_timer1;
	logic      gpio_irq;
	logic      timer0_irq;
	logic      timer1_irq;

	// ------------------------------
	// Reset and bus bridge
	// ------------------------------
	reset_sequencer #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.FLASH_RST_CYCLES(FLASH_RST_CYCLES)
	) u_reset (
		.sys_clk      (sys_clk),
		.trigger_reset(trigger_reset),
		.hard_reset_i (hard_reset),
		.sys_rst_o    (sys_rst),
		.flash_rst_n_o(flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	// Banks drive zero when not addressed, so OR is enough
	wb_csr_bridge u_bridge (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_we_i  (wb_we_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.csr_a_o  (csr_a),
		.csr_we_o (csr_we),
		.csr_dw_o (csr_dw),
		.csr_di_i (csr_dr_gpio | csr_dr_timer0 | csr_dr_timer1)
	);

	// ------------------------------
	// CSR banks
	// ------------------------------
	gpio_ctl #(
		.BANK    (GPIO_BANK),
		.NINPUTS (NINPUTS),
		.NOUTPUTS(NOUTPUTS)
	) u_gpio (
		.sys_clk     (sys_clk),
		.sys_rst_i   (sys_rst),
		.csr_a_i     (csr_a),
		.csr_we_i    (csr_we),
		.csr_di_i    (csr_dw),
		.csr_do_o    (csr_dr_gpio),
		.gpio_in_i   (gpio_in_i),
		.gpio_out_o  (gpio_out_o),
		.irq_o       (gpio_irq),
		.hard_reset_o(hard_reset)
	);

	sys_timer #(.BANK(TIMER0_BANK)) u_timer0 (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst),
		.csr_a_i  (csr_a),
		.csr_we_i (csr_we),
		.csr_di_i (csr_dw),
		.csr_do_o (csr_dr_timer0),
		.irq_o    (timer0_irq)
	);

	sys_timer #(.BANK(TIMER1_BANK)) u_timer1 (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst),
		.csr_a_i  (csr_a),
		.csr_we_i (csr_we),
		.csr_di_i (csr_dw),
		.csr_do_o (csr_dr_timer1),
		.irq_o    (timer1_irq)
	);

	assign irq_o[IRQ_GPIO]   = gpio_irq;
	assign irq_o[IRQ_TIMER0] = timer0_irq;
	assign irq_o[IRQ_TIMER1] = timer1_irq;

endmodule

//--- verification/wb_csr_bridge_sva.sv
// Handshake assertions for the Wishbone to CSR bridge; attached to every bridge instance by bind
`timescale 1ns/1ps

module wb_csr_bridge_sva (
	input logic sys_clk,
	input logic sys_rst_i,
	input logic accept_i,
	input logic wb_ack_i,
	input logic csr_we_i
);

	// Ack is a single-cycle pulse
	ack_one_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		wb_ack_i |=> !wb_ack_i)
		else $error("wb_ack_o stayed high for more than one cycle");

	// One CSR write strobe per access
	we_one_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		csr_we_i |=> !csr_we_i)
		else $error("csr_we_o stayed high for more than one cycle");

	// Fixed latency from acceptance to ack
	ack_latency: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		accept_i |-> ##3 wb_ack_i)
		else $error("wb_ack_o did not follow acceptance after exactly 3 cycles");

endmodule

bind wb_csr_bridge wb_csr_bridge_sva u_bridge_sva (
	.sys_clk  (sys_clk),
	.sys_rst_i(sys_rst_i),
	.accept_i (accept),
	.wb_ack_i (wb_ack_o),
	.csr_we_i (csr_we_o)
);

//--- verification/tb_sysctl.sv
// Testbench for the system controller; runs bus and GPIO stimulus against a register model
`timescale 1ns/1ps

module tb_sysctl;
	import sysctl_pkg::*;

	localparam int NINPUTS          = 7;
	localparam int NOUTPUTS         = 2;
	localparam int DEBOUNCE_CYCLES  = 16;
	localparam int FLASH_RST_CYCLES = 8;
	// Bus accesses issued by the stimulus below
	localparam int NUM_TX           = 65;
	localparam int ACK_LIMIT        = 16;
	localparam int RELEASE_LIMIT    = 40;

	logic                sys_clk;
	logic                trigger_reset;
	wb_addr_t            wb_adr;
	csr_data_t           wb_dat_w;
	logic                wb_we;
	logic                wb_cyc;
	logic                wb_stb;
	csr_data_t           wb_dat_r;
	logic                wb_ack;
	logic [NINPUTS-1:0]  gpio_in;
	logic [NOUTPUTS-1:0] gpio_out;
	irq_vec_t            irq;
	logic                flash_rst_n;
	logic                periph_rst_n;

	int          value_errors;
	int          other_errors;
	logic [31:0] rng_state;
	int          timer0_cmp;
	int          timer1_cmp;

	// Register model
	logic [NOUTPUTS-1:0] m_out;
	logic [NINPUTS-1:0]  m_in;
	logic [NINPUTS-1:0]  m_mask;
	logic [NINPUTS-1:0]  m_pending;
	logic [2:0]          m_ctrl [2];
	csr_data_t           m_cmp [2];
	csr_data_t           m_cnt [2];

	// Reads waiting for comparison
	csr_data_t want_q [$];
	csr_data_t got_q [$];
	wb_addr_t  addr_q [$];

	sysctl_top #(
		.NINPUTS         (NINPUTS),
		.NOUTPUTS        (NOUTPUTS),
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.FLASH_RST_CYCLES(FLASH_RST_CYCLES)
	) dut (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.wb_adr_i      (wb_adr),
		.wb_dat_i      (wb_dat_w),
		.wb_we_i       (wb_we),
		.wb_cyc_i      (wb_cyc),
		.wb_stb_i      (wb_stb),
		.wb_dat_o      (wb_dat_r),
		.wb_ack_o      (wb_ack),
		.gpio_in_i     (gpio_in),
		.gpio_out_o    (gpio_out),
		.irq_o         (irq),
		.flash_rst_n_o (flash_rst_n),
		.periph_rst_n_o(periph_rst_n)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// ------------------------------
	// Helpers and reference model
	// ------------------------------
	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Byte address with the bank in the top nibble of the word address
	function automatic wb_addr_t reg_addr(input csr_bank_t bank, input csr_reg_t idx);
		return {16'h0000, bank, idx, 2'b00};
	endfunction

	function automatic void reset_model();
		m_out     = '0;
		m_mask    = '0;
		m_pending = '0;
		for (int t = 0; t < 2; t++) begin
			m_ctrl[t] = '0;
			m_cmp[t]  = '0;
			m_cnt[t]  = '0;
		end
	endfunction

	// Masked input edges latch into pending
	function automatic void update_inputs(input logic [NINPUTS-1:0] new_in);
		m_pending = m_pending | ((m_in ^ new_in) & m_mask);
		m_in      = new_in;
	endfunction

	function automatic void apply_write(input csr_bank_t bank, input csr_reg_t idx,
		input csr_data_t d);
		int t;
		t = (bank == TIMER1_BANK) ? 1 : 0;
		if (bank == GPIO_BANK) begin
			case (idx)
				GPIO_OUT:     m_out = d[NOUTPUTS-1:0];
				GPIO_MASK:    m_mask = d[NINPUTS-1:0];
				GPIO_PENDING: m_pending = m_pending & ~d[NINPUTS-1:0];
				GPIO_RESET:   if (d == HARD_RESET_KEY) reset_model();
				default:      ;
			endcase
		end else if (bank == TIMER0_BANK || bank == TIMER1_BANK) begin
			case (idx)
				TIMER_CTRL:    m_ctrl[t] = {1'b0, d[1:0]};
				TIMER_COMPARE: m_cmp[t] = d;
				TIMER_COUNTER: m_cnt[t] = d;
				default:       ;
			endcase
		end
	endfunction

	// Compare match sets done; one-shot also stops and holds at compare
	function automatic void apply_timer_match(input int t);
		m_ctrl[t][2] = 1'b1;
		if (!m_ctrl[t][1]) begin
			m_ctrl[t][0] = 1'b0;
			m_cnt[t]     = m_cmp[t];
		end
	endfunction

	function automatic csr_data_t expected_read(input csr_bank_t bank, input csr_reg_t idx);
		csr_data_t v;
		int        t;
		v = '0;
		t = (bank == TIMER1_BANK) ? 1 : 0;
		if (bank == GPIO_BANK) begin
			case (idx)
				GPIO_IN:      v = csr_data_t'(m_in);
				GPIO_OUT:     v = csr_data_t'(m_out);
				GPIO_MASK:    v = csr_data_t'(m_mask);
				GPIO_PENDING: v = csr_data_t'(m_pending);
				default:      v = '0;
			endcase
		end else if (bank == TIMER0_BANK || bank == TIMER1_BANK) begin
			case (idx)
				TIMER_CTRL:    v = csr_data_t'(m_ctrl[t]);
				TIMER_COMPARE: v = m_cmp[t];
				TIMER_COUNTER: v = m_cnt[t];
				default:       v = '0;
			endcase
		end
		return v;
	endfunction

	task automatic report_value(input string what, input csr_data_t got, input csr_data_t want);
		$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, want);
		value_errors++;
	endtask

	// ------------------------------
	// Bus tasks
	// ------------------------------
	// Called on a falling edge with the bridge idle, so the next rising edge accepts
	task automatic bus_access(input wb_addr_t addr, input logic we, input csr_data_t d,
		output csr_data_t q);
		int cycles;
		wb_adr   = addr;
		wb_dat_w = d;
		wb_we    = we;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		cycles   = 0;
		do begin
			@(posedge sys_clk);
			@(negedge sys_clk);
			cycles++;
		end while (!wb_ack && cycles < ACK_LIMIT);
		q      = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		if (!wb_ack) begin
			$display("No ack for the access to address %h within %0d cycles", addr, ACK_LIMIT);
			other_errors++;
		end else if (cycles != 3) begin
			report_value($sformatf("ack latency at %h", addr), csr_data_t'(cycles), 32'd3);
		end
		// Bridge needs its idle cycle after ack
		@(negedge sys_clk);
	endtask

	task automatic wb_write(input csr_bank_t bank, input csr_reg_t idx, input csr_data_t d);
		csr_data_t q;
		bus_access(reg_addr(bank, idx), 1'b1, d, q);
		apply_write(bank, idx, d);
	endtask

	task automatic wb_read(input csr_bank_t bank, input csr_reg_t idx);
		csr_data_t q;
		want_q.push_back(expected_read(bank, idx));
		addr_q.push_back(reg_addr(bank, idx));
		bus_access(reg_addr(bank, idx), 1'b0, '0, q);
		got_q.push_back(q);
	endtask

	task automatic read_timer(input csr_bank_t bank);
		wb_read(bank, TIMER_CTRL);
		wb_read(bank, TIMER_COMPARE);
		wb_read(bank, TIMER_COUNTER);
	endtask

	task automatic read_all_registers();
		wb_read(GPIO_BANK, GPIO_IN);
		wb_read(GPIO_BANK, GPIO_OUT);
		wb_read(GPIO_BANK, GPIO_MASK);
		wb_read(GPIO_BANK, GPIO_PENDING);
		wb_read(GPIO_BANK, GPIO_RESET);
		read_timer(TIMER0_BANK);
		read_timer(TIMER1_BANK);
	endtask

	// Counts rising edges from the last trigger cycle until both resets release
	task automatic check_release(input int start_cycle);
		int cycle;
		int flash_at;
		int periph_at;
		cycle     = start_cycle;
		flash_at  = -1;
		periph_at = -1;
		if (periph_rst_n !== 1'b0 || flash_rst_n !== 1'b0) begin
			$display("Resets were not asserted at the start of the release sequence");
			other_errors++;
		end
		while (periph_at < 0 && cycle < RELEASE_LIMIT) begin
			@(posedge sys_clk);
			@(negedge sys_clk);
			cycle++;
			if (flash_rst_n && flash_at < 0) begin
				flash_at = cycle;
			end
			if (periph_rst_n && periph_at < 0) begin
				periph_at = cycle;
			end
			if (wb_ack !== 1'b0 || gpio_out !== '0 || irq !== '0) begin
				report_value("ack, gpio_out and irq during reset",
					csr_data_t'({wb_ack, gpio_out, irq}), '0);
			end
		end
		if (flash_at != FLASH_RST_CYCLES) begin
			report_value("flash release cycle", csr_data_t'(flash_at), FLASH_RST_CYCLES);
		end
		if (periph_at != DEBOUNCE_CYCLES + 1) begin
			report_value("peripheral release cycle", csr_data_t'(periph_at),
				DEBOUNCE_CYCLES + 1);
		end
	endtask

	task automatic watch_timers(input int window, output int pulses0, output int pulses1);
		pulses0 = 0;
		pulses1 = 0;
		repeat (window) begin
			@(posedge sys_clk);
			@(negedge sys_clk);
			if (irq[IRQ_TIMER0]) begin
				pulses0++;
			end
			if (irq[IRQ_TIMER1]) begin
				pulses1++;
			end
		end
	endtask

	// ------------------------------
	// Read comparison
	// ------------------------------
	always @(negedge sys_clk) begin : compare_reads
		csr_data_t got;
		csr_data_t want;
		wb_addr_t  addr;
		while (got_q.size() > 0) begin
			got  = got_q.pop_front();
			want = want_q.pop_front();
			addr = addr_q.pop_front();
			if (got !== want) begin
				report_value($sformatf("read of %h", addr), got, want);
			end
		end
	end

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial begin : stimulus
		logic [NINPUTS-1:0] mask_v;
		csr_data_t          data;
		int                 order [NINPUTS];
		int                 j;
		int                 tmp;
		int                 p0;
		int                 p1;
		trigger_reset = 1'b1;
		wb_adr        = '0;
		wb_dat_w      = '0;
		wb_we         = 1'b0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		gpio_in       = '0;
		value_errors  = 0;
		other_errors  = 0;
		rng_state     = 32'h98b9_7843;
		m_in          = '0;
		reset_model();
		timer0_cmp = 16 + int'(xorshift32() & 32'd31);
		timer1_cmp = 8 + int'(xorshift32() & 32'd15);

		repeat (3) @(negedge sys_clk);
		trigger_reset = 1'b0;
		check_release(0);
		read_all_registers();

		// Output register and input sampling
		for (int i = 0; i < 6; i++) begin
			data = xorshift32();
			wb_write(GPIO_BANK, GPIO_OUT, data);
			if (gpio_out !== data[NOUTPUTS-1:0]) begin
				report_value("gpio_out", csr_data_t'(gpio_out),
					csr_data_t'(data[NOUTPUTS-1:0]));
			end
			wb_read(GPIO_BANK, GPIO_OUT);
		end
		for (int i = 0; i < 3; i++) begin
			gpio_in = NINPUTS'(xorshift32());
			update_inputs(gpio_in);
			repeat (3) @(negedge sys_clk);
			wb_read(GPIO_BANK, GPIO_IN);
		end
		wb_read(4'd0, csr_reg_t'(xorshift32()));
		wb_read(4'd0, GPIO_OUT);

		// Change interrupts, bits toggled in shuffled order
		mask_v = NINPUTS'(xorshift32());
		mask_v[0] = 1'b1;
		mask_v[NINPUTS-1] = 1'b0;
		wb_write(GPIO_BANK, GPIO_MASK, csr_data_t'(mask_v));
		wb_read(GPIO_BANK, GPIO_MASK);
		for (int i = 0; i < NINPUTS; i++) begin
			order[i] = i;
		end
		for (int i = NINPUTS - 1; i > 0; i--) begin
			j = int'(xorshift32() % 32'(i + 1));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < NINPUTS; i++) begin
			gpio_in[order[i]] = ~gpio_in[order[i]];
			update_inputs(gpio_in);
			repeat (4) @(negedge sys_clk);
			if (irq[IRQ_GPIO] !== (|m_pending)) begin
				report_value("gpio irq", csr_data_t'(irq[IRQ_GPIO]),
					csr_data_t'(|m_pending));
			end
			wb_read(GPIO_BANK, GPIO_PENDING);
		end
		wb_write(GPIO_BANK, GPIO_PENDING, 32'hFFFF_FFFF);
		if (irq[IRQ_GPIO] !== 1'b0) begin
			report_value("gpio irq after clear", csr_data_t'(irq[IRQ_GPIO]), '0);
		end
		wb_read(GPIO_BANK, GPIO_PENDING);

		// Timer0 one-shot
		wb_write(TIMER0_BANK, TIMER_COMPARE, csr_data_t'(timer0_cmp));
		wb_write(TIMER0_BANK, TIMER_COUNTER, '0);
		wb_write(TIMER0_BANK, TIMER_CTRL, 32'd1);
		watch_timers(timer0_cmp + 10, p0, p1);
		if (p0 != 1) begin
			report_value("timer0 irq pulses", csr_data_t'(p0), 32'd1);
		end
		if (p1 != 0) begin
			report_value("timer1 irq pulses", csr_data_t'(p1), '0);
		end
		apply_timer_match(0);
		read_timer(TIMER0_BANK);
		read_timer(TIMER1_BANK);

		// Timer1 with autorestart
		wb_write(TIMER1_BANK, TIMER_COMPARE, csr_data_t'(timer1_cmp));
		wb_write(TIMER1_BANK, TIMER_COUNTER, '0);
		wb_write(TIMER1_BANK, TIMER_CTRL, 32'd3);
		watch_timers(3 * timer1_cmp + 10, p0, p1);
		if (p1 < 2) begin
			report_value("timer1 irq pulses", csr_data_t'(p1), 32'd2);
		end
		apply_timer_match(1);
		wb_read(TIMER1_BANK, TIMER_CTRL);
		wb_read(TIMER1_BANK, TIMER_COMPARE);

		// Hard reset through the GPIO bank
		wb_write(GPIO_BANK, GPIO_RESET, HARD_RESET_KEY);
		check_release(1);
		read_all_registers();

		repeat (2) @(negedge sys_clk);
		if (want_q.size() != 0) begin
			$display("Some reads were never compared against the model");
			other_errors++;
		end
		$display("Error counts: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// ------------------------------
	// Watchdog
	// ------------------------------
	initial begin : watchdog
		int limit;
		#1;
		limit = NUM_TX * 8 + (timer0_cmp + timer1_cmp) * 2 + 100;
		repeat (limit) @(posedge sys_clk);
		$display("Watchdog expired after %0d cycles before the tests finished", limit);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- files.f
hw/sysctl_pkg.sv
hw/reset_sequencer.sv
hw/wb_csr_bridge.sv
hw/gpio_ctl.sv
hw/sys_timer.sv
hw/sysctl_top.sv
verification/wb_csr_bridge_sva.sv
verification/tb_sysctl.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run the testbench and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module tb_sysctl \
	&& ./obj_dir/Vtb_sysctl > sim.log 2>&1 \
	|| echo "TB FAILED" >> sim.log
cat sim.log
if grep -q "TB FAILED" sim.log; then
	exit 1
fi
exit 0
